/* logic/vcu_config.svh */
// ##########################################################
// Vector control unit configuration
// Widths, reduction lane count and vector register size
// ##########################################################
`ifndef VCU_CONFIG_SVH
`define VCU_CONFIG_SVH

// Scalar word width
`define VCU_XLEN 32

// Elements folded per reduction micro-op
`define VCU_LANES 4

// Vector register size in bytes
`define VCU_VLEN_BYTES 16

// Register index width
`define VCU_REGIDX_W 5

`endif

/* logic/vcu_pkg.sv */
// ##########################################################
// Vector control unit types
// Opcodes, selectors and sequencer states
// ##########################################################
`default_nettype none

`include "vcu_config.svh"

package vcu_pkg;

    // Major opcodes, INVALID marks a non-vector instruction
    typedef enum logic [6:0] {
        VMOC_LOAD    = 7'b0000111,
        VMOC_STORE   = 7'b0100111,
        VMOC_ALU_CFG = 7'b1010111,
        VMOC_INVALID = 7'b1111111
    } vmajor_op_t;

    // Arithmetic format field
    typedef enum logic [2:0] {
        OPIVV, OPFVV, OPMVV, OPIVI, OPIVX, OPFVF, OPMVX, OPCFG
    } vfunct3_t;

    typedef enum logic [1:0] {
        NOT_CFG, VSETVLI, VSETIVLI, VSETVL
    } vsetvl_t;

    // Memory addressing mode
    typedef enum logic [1:0] {
        MOP_UNIT     = 2'd0,
        MOP_UINDEXED = 2'd1,
        MOP_STRIDED  = 2'd2,
        MOP_OINDEXED = 2'd3
    } mop_t;

    typedef enum logic [1:0] {
        SEW8, SEW16, SEW32
    } vsew_t;

    // Functional unit select
    typedef enum logic [1:0] {
        VFU_ALU, VFU_RED, VFU_PASS_VS2
    } vfu_t;

    typedef enum logic {
        RC_VECTOR, RC_SCRATCH
    } regclass_t;

    typedef struct packed {
        regclass_t                  regclass;
        logic [`VCU_REGIDX_W-1:0]   regidx;
    } regsel_t;

    // Reduction sequencer states
    typedef enum logic [1:0] {
        REDC_IDLE, REDC_UNTIL_4, REDC_LAST_4, REDC_FINAL
    } red_state_t;

endpackage

`default_nettype wire

/* logic/vcu_ctrl_if.sv */
// ##########################################################
// Control word passed between the control unit stages
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

`include "vcu_config.svh"

interface vcu_ctrl_if
    import vcu_pkg::*;
();
    logic                   valid;
    vsetvl_t                vsetvl_type;
    logic                   keepvl, sregwen, vregwen;
    // Memory access mode
    logic                   memdren, memdwen, unitstride, strided, indexed;
    // Effective element widths
    vsew_t                  veew_src1, veew_src2, veew_dest;
    logic [`VCU_XLEN-1:0]   evl;
    vfu_t                   vfu;
    logic                   mask_en, busy;
    regsel_t                vd_sel, vs1_sel, vs2_sel;
    // Integer reduction recognized
    logic                   red;

    modport src (
        output valid, vsetvl_type, keepvl, sregwen, vregwen,
        output memdren, memdwen, unitstride, strided, indexed,
        output veew_src1, veew_src2, veew_dest, evl, vfu, mask_en, busy,
        output vd_sel, vs1_sel, vs2_sel, red
    );

    modport dst (
        input valid, vsetvl_type, keepvl, sregwen, vregwen,
        input memdren, memdwen, unitstride, strided, indexed,
        input veew_src1, veew_src2, veew_dest, evl, vfu, mask_en, busy,
        input vd_sel, vs1_sel, vs2_sel, red
    );

endinterface

`default_nettype wire

/* logic/vcu_field_decode.sv */
// ##########################################################
// Vector instruction field decode
// Builds the raw control word and the effective vl
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

`include "vcu_config.svh"

module vcu_field_decode
    import vcu_pkg::*;
(
    input  logic [`VCU_XLEN-1:0]    instr,
    input  logic [`VCU_XLEN-1:0]    vl,
    input  vsew_t                   vsew,
    vcu_ctrl_if.src                 ctrl
);

    vmajor_op_t             major;
    vfunct3_t               funct3;
    mop_t                   mop;
    vsetvl_t                vset_type;
    vsew_t                  mem_eew;
    vsew_t                  eew_src1, eew_src2, eew_dest;
    logic                   is_cfg, is_mem, is_store, is_red;
    logic [4:0]             lumop;
    logic [`VCU_XLEN-1:0]   mask_evl, whole_evl, nf_regs;

    // Major opcode, anything unknown is not a vector instruction
    always_comb begin
        case (instr[6:0])
            VMOC_LOAD:    major = VMOC_LOAD;
            VMOC_STORE:   major = VMOC_STORE;
            VMOC_ALU_CFG: major = VMOC_ALU_CFG;
            default:      major = VMOC_INVALID;
        endcase
    end

    assign funct3   = vfunct3_t'(instr[14:12]);
    assign mop      = mop_t'(instr[27:26]);
    assign lumop    = instr[24:20];
    assign is_cfg   = (major == VMOC_ALU_CFG) && (funct3 == OPCFG);
    assign is_store = (major == VMOC_STORE);
    assign is_mem   = (major == VMOC_LOAD) || is_store;

    // vset* flavour from the top two bits
    always_comb begin
        vset_type = NOT_CFG;
        if (is_cfg) begin
            casez (instr[31:30])
                2'b0?:   vset_type = VSETVLI;
                2'b11:   vset_type = VSETIVLI;
                default: vset_type = VSETVL;
            endcase
        end
    end

    assign ctrl.valid       = (major != VMOC_INVALID);
    assign ctrl.vsetvl_type = vset_type;
    // rs1 = rd = x0 keeps the current vl
    assign ctrl.keepvl      = ((vset_type == VSETVLI) || (vset_type == VSETVL)) &&
                              (instr[19:15] == 5'd0) && (instr[11:7] == 5'd0);
    assign ctrl.sregwen     = is_cfg;
    assign ctrl.vregwen     = ctrl.valid && !is_store && !is_cfg;

    assign ctrl.memdren    = (major == VMOC_LOAD);
    assign ctrl.memdwen    = is_store;
    assign ctrl.unitstride = is_mem && (mop == MOP_UNIT);
    assign ctrl.strided    = is_mem && (mop == MOP_STRIDED);
    assign ctrl.indexed    = is_mem && ((mop == MOP_UINDEXED) || (mop == MOP_OINDEXED));

    // Memory EEW from the width field
    always_comb begin
        case (instr[14:12])
            3'd0:    mem_eew = SEW8;
            3'd5:    mem_eew = SEW16;
            default: mem_eew = SEW32;
        endcase
    end

    always_comb begin
        eew_src1 = vsew;
        eew_src2 = vsew;
        eew_dest = vsew;
        // Data side of plain loads and stores
        if (is_mem && !ctrl.indexed) begin
            eew_src1 = mem_eew;
            eew_dest = mem_eew;
        end
        // Index vector of indexed accesses
        if (ctrl.indexed) begin
            eew_src2 = mem_eew;
        end
    end

    assign ctrl.veew_src1 = eew_src1;
    assign ctrl.veew_src2 = eew_src2;
    assign ctrl.veew_dest = eew_dest;

    // Mask access covers ceil(vl/8) bytes
    assign mask_evl  = (vl >> 3) + `VCU_XLEN'(|vl[2:0]);
    // Whole register count times register bytes, over element size
    assign nf_regs   = `VCU_XLEN'(instr[31:29]) + `VCU_XLEN'(1);
    assign whole_evl = (nf_regs * `VCU_VLEN_BYTES) >> eew_dest;

    always_comb begin
        ctrl.evl = vl;
        if (is_mem && (lumop == 5'b01011)) begin
            ctrl.evl = mask_evl;
        end else if (is_mem && (lumop == 5'b01000)) begin
            ctrl.evl = whole_evl;
        end
    end

    // Register selects, a store reads its data through vs1
    assign ctrl.vd_sel  = '{regclass: RC_VECTOR, regidx: instr[11:7]};
    assign ctrl.vs1_sel = '{regclass: RC_VECTOR,
                            regidx: is_store ? instr[11:7] : instr[19:15]};
    assign ctrl.vs2_sel = '{regclass: RC_VECTOR, regidx: instr[24:20]};

    assign ctrl.mask_en = (funct3 != OPCFG) && !instr[25];

    // Only the OPMVV integer reduction group
    assign is_red   = (major == VMOC_ALU_CFG) && (funct3 == OPMVV) &&
                      (instr[31:29] == 3'b000);
    assign ctrl.red  = is_red;
    assign ctrl.vfu  = is_red ? VFU_RED : VFU_ALU;
    assign ctrl.busy = 1'b0;

endmodule

`default_nettype wire

/* logic/vcu_red_seq.sv */
// ##########################################################
// Reduction sequencer
// Steps a reduction through the scratch register
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

`include "vcu_config.svh"

module vcu_red_seq
    import vcu_pkg::*;
(
    input  logic        CLK,
    input  logic        nRST,
    input  logic        stall,
    vcu_ctrl_if.dst     dec,
    vcu_ctrl_if.src     fin
);

    localparam regsel_t SCRATCH = '{regclass: RC_SCRATCH, regidx: '0};

    red_state_t             state, next_state;
    // Elements still to fold before the last four
    logic [`VCU_XLEN-1:0]   remain, next_remain;

    // Fields the sequencer never changes
    assign fin.valid       = dec.valid;
    assign fin.vsetvl_type = dec.vsetvl_type;
    assign fin.keepvl      = dec.keepvl;
    assign fin.sregwen     = dec.sregwen;
    assign fin.vregwen     = dec.vregwen;
    assign fin.memdren     = dec.memdren;
    assign fin.memdwen     = dec.memdwen;
    assign fin.unitstride  = dec.unitstride;
    assign fin.strided     = dec.strided;
    assign fin.indexed     = dec.indexed;
    assign fin.veew_src1   = dec.veew_src1;
    assign fin.veew_src2   = dec.veew_src2;
    assign fin.veew_dest   = dec.veew_dest;
    assign fin.red         = dec.red;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state  <= REDC_IDLE;
            remain <= '0;
        end else if (!stall) begin
            state  <= next_state;
            remain <= next_remain;
        end
    end

    // For a reduction dec.evl carries vl unchanged
    always_comb begin
        fin.vfu     = dec.vfu;
        fin.vd_sel  = dec.vd_sel;
        fin.vs1_sel = dec.vs1_sel;
        fin.vs2_sel = dec.vs2_sel;
        fin.evl     = dec.evl;
        fin.mask_en = dec.mask_en;
        fin.busy    = dec.busy;
        next_state  = state;
        next_remain = remain;

        case (state)
            REDC_IDLE: begin
                if (dec.red && (dec.evl > `VCU_LANES)) begin
                    // Copy vs2 into scratch, then fold down to four
                    fin.vfu     = VFU_PASS_VS2;
                    fin.vd_sel  = SCRATCH;
                    fin.busy    = 1'b1;
                    next_remain = dec.evl - `VCU_LANES;
                    next_state  = REDC_UNTIL_4;
                end else if (dec.red && (dec.evl > 1)) begin
                    // Few enough to reduce straight into scratch
                    fin.vfu    = VFU_RED;
                    fin.vd_sel = SCRATCH;
                    fin.busy   = 1'b1;
                    next_state = REDC_FINAL;
                end else if (dec.red) begin
                    // Single element is a plain op into vd
                    fin.vfu = VFU_ALU;
                end
            end
            REDC_UNTIL_4: begin
                fin.vfu     = VFU_ALU;
                fin.vd_sel  = SCRATCH;
                fin.vs1_sel = SCRATCH;
                fin.evl     = remain;
                fin.busy    = 1'b1;
                if (remain <= `VCU_LANES) begin
                    next_state = REDC_LAST_4;
                end else begin
                    next_remain = remain - `VCU_LANES;
                end
            end
            REDC_LAST_4: begin
                // Fold the last four lanes into scratch element 0
                fin.vfu     = VFU_RED;
                fin.vd_sel  = SCRATCH;
                fin.vs2_sel = SCRATCH;
                fin.evl     = `VCU_XLEN'(`VCU_LANES);
                fin.mask_en = 1'b0;
                fin.busy    = 1'b1;
                next_state  = REDC_FINAL;
            end
            REDC_FINAL: begin
                // Combine with vs1[0] and write vd
                fin.vfu     = VFU_ALU;
                fin.vs2_sel = SCRATCH;
                fin.evl     = `VCU_XLEN'(1);
                fin.mask_en = 1'b0;
                fin.busy    = 1'b0;
                next_state  = REDC_IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/vcu_ctrl_reg.sv */
// ##########################################################
// Control word output register, holds under stall
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module vcu_ctrl_reg (
    input  logic        CLK,
    input  logic        nRST,
    input  logic        stall,
    vcu_ctrl_if.dst     fin,
    vcu_ctrl_if.src     out
);

    // Enables and flags
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            out.valid      <= 1'b0;
            out.keepvl     <= 1'b0;
            out.sregwen    <= 1'b0;
            out.vregwen    <= 1'b0;
            out.memdren    <= 1'b0;
            out.memdwen    <= 1'b0;
            out.unitstride <= 1'b0;
            out.strided    <= 1'b0;
            out.indexed    <= 1'b0;
            out.mask_en    <= 1'b0;
            out.busy       <= 1'b0;
            out.red        <= 1'b0;
        end else if (!stall) begin
            out.valid      <= fin.valid;
            out.keepvl     <= fin.keepvl;
            out.sregwen    <= fin.sregwen;
            out.vregwen    <= fin.vregwen;
            out.memdren    <= fin.memdren;
            out.memdwen    <= fin.memdwen;
            out.unitstride <= fin.unitstride;
            out.strided    <= fin.strided;
            out.indexed    <= fin.indexed;
            out.mask_en    <= fin.mask_en;
            out.busy       <= fin.busy;
            out.red        <= fin.red;
        end
    end

    // Payload fields
    always_ff @(posedge CLK) begin
        if (!stall) begin
            out.vsetvl_type <= fin.vsetvl_type;
            out.veew_src1   <= fin.veew_src1;
            out.veew_src2   <= fin.veew_src2;
            out.veew_dest   <= fin.veew_dest;
            out.evl         <= fin.evl;
            out.vfu         <= fin.vfu;
            out.vd_sel      <= fin.vd_sel;
            out.vs1_sel     <= fin.vs1_sel;
            out.vs2_sel     <= fin.vs2_sel;
        end
    end

endmodule

`default_nettype wire

/* logic/vector_control_unit.sv */
// ##########################################################
// Vector control unit top
// Decode, reduction sequencing and output register
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

`include "vcu_config.svh"

module vector_control_unit
    import vcu_pkg::*;
(
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic [`VCU_XLEN-1:0]    instr,
    input  logic [`VCU_XLEN-1:0]    vl,
    input  vsew_t                   vsew,
    input  logic                    stall,
    output logic                    valid, keepvl, sregwen, vregwen,
    output vsetvl_t                 vsetvl_type,
    output logic                    memdren, memdwen, unitstride, strided, indexed,
    output vsew_t                   veew_src1, veew_src2, veew_dest,
    output logic [`VCU_XLEN-1:0]    evl,
    output vfu_t                    vfu,
    output logic                    mask_en, busy, red,
    output regsel_t                 vd_sel, vs1_sel, vs2_sel
);

    vcu_ctrl_if dec_if ();
    vcu_ctrl_if fin_if ();
    vcu_ctrl_if out_if ();

    vcu_field_decode u_field_decode (
        .instr (instr),
        .vl    (vl),
        .vsew  (vsew),
        .ctrl  (dec_if.src)
    );

    vcu_red_seq u_red_seq (
        .CLK   (CLK),
        .nRST  (nRST),
        .stall (stall),
        .dec   (dec_if.dst),
        .fin   (fin_if.src)
    );

    vcu_ctrl_reg u_ctrl_reg (
        .CLK   (CLK),
        .nRST  (nRST),
        .stall (stall),
        .fin   (fin_if.dst),
        .out   (out_if.src)
    );

    // Registered control word onto plain ports
    assign valid       = out_if.valid;
    assign vsetvl_type = out_if.vsetvl_type;
    assign keepvl      = out_if.keepvl;
    assign sregwen     = out_if.sregwen;
    assign vregwen     = out_if.vregwen;
    assign memdren     = out_if.memdren;
    assign memdwen     = out_if.memdwen;
    assign unitstride  = out_if.unitstride;
    assign strided     = out_if.strided;
    assign indexed     = out_if.indexed;
    assign veew_src1   = out_if.veew_src1;
    assign veew_src2   = out_if.veew_src2;
    assign veew_dest   = out_if.veew_dest;
    assign evl         = out_if.evl;
    assign vfu         = out_if.vfu;
    assign mask_en     = out_if.mask_en;
    assign busy        = out_if.busy;
    assign vd_sel      = out_if.vd_sel;
    assign vs1_sel     = out_if.vs1_sel;
    assign vs2_sel     = out_if.vs2_sel;
    assign red         = out_if.red;

endmodule

`default_nettype wire

/* dv/vcu_clk_gen.sv */
// ##########################################################
// Testbench clock (40 ns) and 16-cycle reset
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module vcu_clk_gen (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // Reset held low for the first 16 rising edges
    initial begin
        nRST = 1'b0;
        repeat (16) @(posedge CLK);
        nRST <= 1'b1;
    end

endmodule

`default_nettype wire

/* dv/vcu_assertions.sv */
// ##########################################################
// Concurrent checks of the vector control unit outputs
// Compared against the last unstalled instruction
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

`include "vcu_config.svh"

module vcu_assertions
    import vcu_pkg::*;
(
    input logic                     CLK,
    input logic                     nRST,
    input logic                     stall,
    input logic [`VCU_XLEN-1:0]     instr,
    input logic [`VCU_XLEN-1:0]     vl,
    input vsew_t                    vsew,
    input logic                     valid, keepvl, sregwen, vregwen,
    input vsetvl_t                  vsetvl_type,
    input logic                     memdren, memdwen, unitstride, strided, indexed,
    input vsew_t                    veew_src1, veew_src2, veew_dest,
    input logic [`VCU_XLEN-1:0]     evl,
    input vfu_t                     vfu,
    input logic                     mask_en, busy, red,
    input regsel_t                  vd_sel, vs1_sel, vs2_sel
);

    int                     fail_count = 0;
    logic                   seen;
    logic [`VCU_XLEN-1:0]   cap_instr, cap_vl;
    vsew_t                  cap_vsew;
    // Unstalled cycles of the current busy run
    int                     run_len;

    logic                   c_vec, c_cfg, c_mem, c_st, c_idx, c_red, c_keep;
    vsetvl_t                c_kind;
    vsew_t                  m_eew, d_eew, s1_eew, s2_eew;
    logic [`VCU_XLEN-1:0]   c_evl;
    logic [4:0]             c_vs1;
    int                     c_run;

    // Instruction behind the registered outputs
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            seen      <= 1'b0;
            cap_instr <= '0;
            cap_vl    <= '0;
            cap_vsew  <= SEW8;
            run_len   <= 0;
        end else if (!stall) begin
            seen      <= 1'b1;
            cap_instr <= instr;
            cap_vl    <= vl;
            cap_vsew  <= vsew;
            run_len   <= busy ? run_len + 1 : 0;
        end
    end

    // Expected decode of the captured word
    always_comb begin
        c_vec  = (cap_instr[6:0] == 7'b0000111) || (cap_instr[6:0] == 7'b0100111) ||
                 (cap_instr[6:0] == 7'b1010111);
        c_cfg  = (cap_instr[6:0] == 7'b1010111) && (cap_instr[14:12] == 3'b111);
        c_st   = (cap_instr[6:0] == 7'b0100111);
        c_mem  = c_st || (cap_instr[6:0] == 7'b0000111);
        c_idx  = cap_instr[26];
        c_red  = (cap_instr[6:0] == 7'b1010111) && (cap_instr[14:12] == 3'b010) &&
                 (cap_instr[31:29] == 3'b000);
        c_kind = !cap_instr[31] ? VSETVLI : (cap_instr[30] ? VSETIVLI : VSETVL);
        c_keep = (cap_instr[31:30] != 2'b11) && (cap_instr[19:15] == 5'd0) &&
                 (cap_instr[11:7] == 5'd0);
        m_eew  = (cap_instr[14:12] == 3'd0) ? SEW8 :
                 ((cap_instr[14:12] == 3'd5) ? SEW16 : SEW32);
        d_eew  = c_idx ? cap_vsew : m_eew;
        s1_eew = c_idx ? cap_vsew : m_eew;
        s2_eew = c_idx ? m_eew : cap_vsew;
        // Store data register vs3 sits in the rd field
        c_vs1  = c_st ? cap_instr[11:7] : cap_instr[19:15];
        c_evl  = cap_vl;
        if (cap_instr[24:20] == 5'b01011) begin
            c_evl = (cap_vl + 32'd7) / 32'd8;
        end else if (cap_instr[24:20] == 5'b01000) begin
            c_evl = (({29'd0, cap_instr[31:29]} + 32'd1) * 32'd16) >> d_eew;
        end
        // Busy length of a reduction over cap_vl
        c_run = 0;
        if (cap_vl > 32'd4) begin
            c_run = 2 + int'((cap_vl - 32'd4 + 32'd3) / 32'd4);
        end else if (cap_vl > 32'd1) begin
            c_run = 1;
        end
    end

    a_reset: assert property (@(posedge CLK) (!nRST && $past(!nRST)) |->
        (!valid && !busy && !sregwen && !vregwen && !memdren && !memdwen && !mask_en))
        else begin
            $error("** Error valid %h busy %h sregwen %h vregwen %h exp 0 in reset",
                   $sampled(valid), $sampled(busy), $sampled(sregwen),
                   $sampled(vregwen));
            fail_count++;
        end

    a_invalid: assert property (@(posedge CLK) disable iff (!nRST)
        (seen && !c_vec) |-> (!valid && !vregwen && !sregwen && !memdren && !memdwen))
        else begin
            $error("** Error valid %h vregwen %h sregwen %h memdren %h memdwen %h exp 0",
                   $sampled(valid), $sampled(vregwen), $sampled(sregwen),
                   $sampled(memdren), $sampled(memdwen));
            fail_count++;
        end

    a_vset: assert property (@(posedge CLK) disable iff (!nRST)
        (seen && c_cfg) |->
        (vsetvl_type == c_kind && keepvl == c_keep && sregwen && !vregwen))
        else begin
            $error("** Error vsetvl_type %h exp %h keepvl %h exp %h sregwen %h vregwen %h",
                   $sampled(vsetvl_type), $sampled(c_kind), $sampled(keepvl),
                   $sampled(c_keep), $sampled(sregwen), $sampled(vregwen));
            fail_count++;
        end

    // Unit for mop 0, strided for 2, indexed for odd mop
    a_mem_mode: assert property (@(posedge CLK) disable iff (!nRST)
        (seen && c_mem) |->
        (memdren == !c_st && memdwen == c_st && vregwen == !c_st &&
         unitstride == (cap_instr[27:26] == 2'd0) &&
         strided == (cap_instr[27:26] == 2'd2) && indexed == c_idx))
        else begin
            $error("** Error memdwen %h exp %h mode %h exp mop %h vregwen %h",
                   $sampled(memdwen), $sampled(c_st),
                   $sampled({unitstride, strided, indexed}),
                   $sampled(cap_instr[27:26]), $sampled(vregwen));
            fail_count++;
        end

    a_mem_eew: assert property (@(posedge CLK) disable iff (!nRST)
        (seen && c_mem) |->
        (veew_src1 == s1_eew && veew_src2 == s2_eew && veew_dest == d_eew && evl == c_evl))
        else begin
            $error("** Error veew %h exp %h evl %h exp %h",
                   $sampled({veew_src1, veew_src2, veew_dest}),
                   $sampled({s1_eew, s2_eew, d_eew}), $sampled(evl), $sampled(c_evl));
            fail_count++;
        end

    a_mem_vs1: assert property (@(posedge CLK) disable iff (!nRST)
        (seen && c_mem) |->
        (vs1_sel.regclass == RC_VECTOR && vs1_sel.regidx == c_vs1))
        else begin
            $error("** Error vs1_sel %h exp index %h", $sampled(vs1_sel),
                   $sampled(c_vs1));
            fail_count++;
        end

    a_red_flag: assert property (@(posedge CLK) disable iff (!nRST)
        seen |-> (red == c_red))
        else begin
            $error("** Error red %h exp %h", $sampled(red), $sampled(c_red));
            fail_count++;
        end

    a_red_short: assert property (@(posedge CLK) disable iff (!nRST)
        (seen && c_red && cap_vl <= 32'd1) |-> (!busy && vfu == VFU_ALU))
        else begin
            $error("** Error busy %h vfu %h exp 0 and %h", $sampled(busy),
                   $sampled(vfu), VFU_ALU);
            fail_count++;
        end

    // Output right after busy falls is the FINAL step
    a_red_final: assert property (@(posedge CLK) disable iff (!nRST)
        (run_len != 0 && !busy) |->
        (run_len == c_run && vfu == VFU_ALU && !mask_en && vs2_sel.regclass == RC_SCRATCH &&
         vd_sel.regclass == RC_VECTOR && vd_sel.regidx == cap_instr[11:7] &&
         vs1_sel.regclass == RC_VECTOR && vs1_sel.regidx == cap_instr[19:15]))
        else begin
            $error("** Error busy run %h exp %h vfu %h vd_sel %h vs1_sel %h vs2_sel %h",
                   $sampled(run_len), $sampled(c_run), $sampled(vfu),
                   $sampled(vd_sel), $sampled(vs1_sel), $sampled(vs2_sel));
            fail_count++;
        end

    a_stall: assert property (@(posedge CLK) disable iff (!nRST)
        stall |=> $stable({valid, keepvl, sregwen, vregwen, vsetvl_type, memdren, memdwen,
                           unitstride, strided, indexed, veew_src1, veew_src2, veew_dest,
                           evl, vfu, mask_en, busy, red, vd_sel, vs1_sel, vs2_sel}))
        else begin
            $error("Outputs changed under stall, busy %h evl %h", $sampled(busy),
                   $sampled(evl));
            fail_count++;
        end

endmodule

`default_nettype wire

/* dv/vcu_tb.sv */
// ##########################################################
// Vector control unit testbench
// Random decode stimulus, reductions and stalls
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

`include "vcu_config.svh"

module vcu_tb
    import vcu_pkg::*;
();

    localparam int N_INVALID = 16;
    localparam int N_CFG     = 16;
    localparam int N_MEM     = 40;
    localparam int N_LONG    = 8;
    // Longest reduction (vl 36) holds 11 captures
    // Random stall may double that
    localparam int N_TESTS        = 2 * N_INVALID + N_CFG + N_MEM + 5 + N_LONG + 1;
    localparam int TIMEOUT_CYCLES = 16 + N_TESTS * 12 * 2 + 20;

    logic                   CLK, nRST, stall;
    logic [`VCU_XLEN-1:0]   instr, vl;
    vsew_t                  vsew;
    logic                   valid, keepvl, sregwen, vregwen;
    logic                   memdren, memdwen, unitstride, strided, indexed;
    logic                   mask_en, busy, red;
    vsetvl_t                vsetvl_type;
    vsew_t                  veew_src1, veew_src2, veew_dest;
    logic [`VCU_XLEN-1:0]   evl;
    vfu_t                   vfu;
    regsel_t                vd_sel, vs1_sel, vs2_sel;

    logic [31:0]            lfsr_state = 32'h4ad1fccd;
    logic                   stall_on;
    int                     cycles = 0;
    int                     timeouts = 0;

    vcu_clk_gen u_clk_gen (
        .CLK  (CLK),
        .nRST (nRST)
    );

    vector_control_unit u_vector_control_unit (.*);

    bind vector_control_unit vcu_assertions u_vcu_assertions (.*);

    // Fibonacci LFSR with taps 32 22 2 1
    // One step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val        = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic vsew_t pick_sew();
        logic [31:0] r;
        r = rand_bits(2);
        return (r == 32'd0) ? SEW8 : ((r == 32'd1) ? SEW16 : SEW32);
    endfunction

    // Busy cycles of a reduction over len elements
    function automatic int red_holds(input logic [31:0] len);
        if (len <= 32'd1) begin
            return 0;
        end
        if (len <= 32'd4) begin
            return 1;
        end
        return 2 + int'((len - 32'd4 + 32'd3) / 32'd4);
    endfunction

    // Present one word and keep it for holds+1 unstalled edges
    task automatic issue(input logic [31:0] word, input logic [31:0] len, input int holds);
        int captures;
        captures = 0;
        instr <= word;
        vl    <= len;
        vsew  <= pick_sew();
        while (captures <= holds) begin
            @(posedge CLK);
            if (!stall) begin
                captures++;
            end
            stall <= stall_on && (rand_bits(1) != 32'd0);
        end
    endtask

    task automatic invalid_words();
        logic [31:0] word;
        repeat (N_INVALID) begin
            word = rand_bits(32);
            while ((word[6:0] == 7'b0000111) || (word[6:0] == 7'b0100111) ||
                   (word[6:0] == 7'b1010111)) begin
                word = rand_bits(32);
            end
            issue(word, rand_bits(6), 0);
        end
    endtask

    task automatic vset_words();
        logic [31:0] word;
        repeat (N_CFG) begin
            word        = rand_bits(32);
            word[6:0]   = 7'b1010111;
            word[14:12] = 3'b111;
            // Half of them with rs1 = rd = x0
            if (rand_bits(1) != 32'd0) begin
                word[19:15] = 5'd0;
                word[11:7]  = 5'd0;
            end
            issue(word, rand_bits(6), 0);
        end
    endtask

    task automatic mem_words();
        logic [31:0] word;
        repeat (N_MEM) begin
            word      = rand_bits(32);
            word[6:0] = (rand_bits(1) != 32'd0) ? 7'b0000111 : 7'b0100111;
            case (rand_bits(2))
                32'd0:   word[14:12] = 3'd0;
                32'd1:   word[14:12] = 3'd5;
                default: word[14:12] = 3'd6;
            endcase
            // Mask or whole-register lumop in half the cases
            case (rand_bits(2))
                32'd0:   word[24:20] = 5'b01011;
                32'd1:   word[24:20] = 5'b01000;
                default: word[24:20] = word[24:20];
            endcase
            issue(word, rand_bits(8), 0);
        end
    endtask

    task automatic reduction(input logic [31:0] len);
        logic [31:0] word;
        word        = rand_bits(32);
        word[6:0]   = 7'b1010111;
        word[14:12] = 3'b010;
        word[31:29] = 3'b000;
        issue(word, len, red_holds(len));
    endtask

    task automatic report_and_finish();
        int errors;
        errors = u_vector_control_unit.u_vcu_assertions.fail_count + timeouts;
        $display("Errors: %0d assertion, %0d timeout",
                 u_vector_control_unit.u_vcu_assertions.fail_count, timeouts);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            timeouts = 1;
            $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
            report_and_finish();
        end
    end

    initial begin
        instr    = '0;
        vl       = '0;
        vsew     = SEW8;
        stall    = 1'b0;
        stall_on = 1'b0;
        @(posedge nRST);
        @(posedge CLK);
        invalid_words();
        vset_words();
        mem_words();
        // Short reductions over vl 0 to 4
        for (int v = 0; v <= 4; v++) begin
            reduction(32'(v));
        end
        repeat (N_LONG) begin
            reduction(32'd5 + rand_bits(5));
        end
        // One reduction under random stall
        stall_on = 1'b1;
        reduction(32'd23);
        stall_on = 1'b0;
        // Trailing words also flush the last reduction
        invalid_words();
        report_and_finish();
    end

endmodule

`default_nettype wire

/* vector_control_unit.f */
+incdir+logic
logic/vcu_pkg.sv
logic/vcu_ctrl_if.sv
logic/vcu_field_decode.sv
logic/vcu_red_seq.sv
logic/vcu_ctrl_reg.sv
logic/vector_control_unit.sv
dv/vcu_clk_gen.sv
dv/vcu_assertions.sv
dv/vcu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the vector control unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f vector_control_unit.f --top-module vcu_tb -o vcu_sim

# Assertion errors must not stop the run before the closing line
output=$(./obj_dir/vcu_sim +verilator+error+limit+1000 2>&1) || true
echo "$output"

if grep -q "Simulation passed" <<< "$output"; then
    exit 0
fi
exit 1
